//--- hdl/ppu_pkg.sv
`default_nettype none

package ppu_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [15:0] cpu_addr_t;
	typedef logic [10:0] vram_addr_t; // 2 KB video RAM
	typedef logic [7:0]  pixel_t;     // RGB332
	typedef logic [7:0]  fb_coord_t;
	typedef logic [9:0]  scan_cnt_t;  // VGA line and column counters

	// CPU side register map
	localparam cpu_addr_t REG_CTRL   = 16'h2000;
	localparam cpu_addr_t REG_COLOR  = 16'h2001;
	localparam cpu_addr_t REG_STATUS = 16'h2002;
	localparam cpu_addr_t REG_SCROLL = 16'h2005;
	localparam cpu_addr_t REG_VADDR  = 16'h2006;
	localparam cpu_addr_t REG_VDATA  = 16'h2007;
	localparam cpu_addr_t REG_JOY1   = 16'h4016;
	localparam cpu_addr_t REG_JOY2   = 16'h4017;

	localparam int VRAM_SIZE = 2048;
	localparam vram_addr_t PATTERN_BASE = 11'h400; // 128 tiles, 8 bytes each

	// Frame buffer
	localparam int FB_W    = 256;
	localparam int FB_H    = 240;
	localparam int FB_SIZE = FB_W * FB_H;

	// 640x480 timing, both syncs active low
	localparam int H_ACTIVE = 640;
	localparam int H_FP     = 16;
	localparam int H_SYNC   = 96;
	localparam int H_BP     = 48;
	localparam int H_TOTAL  = H_ACTIVE + H_FP + H_SYNC + H_BP;
	localparam int V_ACTIVE = 480;
	localparam int V_FP     = 10;
	localparam int V_SYNC   = 2;
	localparam int V_BP     = 33;
	localparam int V_TOTAL  = V_ACTIVE + V_FP + V_SYNC + V_BP;

endpackage

`default_nettype wire

//--- hdl/ppu_reg_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ppu_reg_if;
	import ppu_pkg::*;

	logic      render_en;
	pixel_t    fg_color;
	fb_coord_t scroll_x;
	fb_coord_t scroll_y; // Must stay below 240
	logic      busy;     // Renderer is drawing a frame

	modport ctrl (
		output render_en, fg_color, scroll_x, scroll_y,
		input  busy
	);

	modport render (
		input  render_en, fg_color, scroll_x, scroll_y,
		output busy
	);
endinterface

`default_nettype wire

//--- hdl/pix_wr_if.sv
`timescale 1ns/1ps
`default_nettype none

interface pix_wr_if;
	import ppu_pkg::*;

	fb_coord_t row;
	fb_coord_t col;
	pixel_t    data;
	logic      write_en;

	modport src (
		output row, col, data, write_en
	);

	modport dst (
		input row, col, data, write_en
	);
endinterface

`default_nettype wire

//--- hdl/mem_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire ppu_pkg::cpu_addr_t  cpu_addr,
	input  wire ppu_pkg::byte_t      cpu_wdata,
	input  wire                  cpu_write_en,
	input  wire                  cpu_read_en,
	input  wire ppu_pkg::byte_t      joy_1,
	input  wire ppu_pkg::byte_t      joy_2,
	input  wire                  vga_done,
	input  wire ppu_pkg::vram_addr_t ppu_vram_addr,
	output ppu_pkg::byte_t           cpu_rdata,
	output ppu_pkg::byte_t           ppu_vram_data,
	output logic                 vblank,
	ppu_reg_if.ctrl              regs
);
	import ppu_pkg::*;

	byte_t      vram [VRAM_SIZE];
	vram_addr_t vaddr;     // CPU side VRAM pointer
	logic       toggle;    // Shared by REG_SCROLL and REG_VADDR
	logic       render_en;
	pixel_t     fg_color;
	fb_coord_t  scroll_x;
	fb_coord_t  scroll_y;
	byte_t      rd_mux;
	logic       wr_vdata;
	logic       rd_vdata;
	logic       rd_status;

	assign wr_vdata  = cpu_write_en && (cpu_addr == REG_VDATA);
	assign rd_vdata  = cpu_read_en && (cpu_addr == REG_VDATA);
	assign rd_status = cpu_read_en && (cpu_addr == REG_STATUS);

	assign regs.render_en = render_en;
	assign regs.fg_color  = fg_color;
	assign regs.scroll_x  = scroll_x;
	assign regs.scroll_y  = scroll_y;

	// Read data, flags as they were before the access
	always_comb begin
		case (cpu_addr)
			REG_STATUS: rd_mux = {vblank, regs.busy, 6'b0};
			REG_VDATA:  rd_mux = vram[vaddr]; // No read buffer
			REG_JOY1:   rd_mux = joy_1;
			REG_JOY2:   rd_mux = joy_2;
			default:    rd_mux = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cpu_rdata <= '0;
			vblank    <= 1'b0;
			toggle    <= 1'b0;
			render_en <= 1'b0;
			fg_color  <= '0;
			scroll_x  <= '0;
			scroll_y  <= '0;
			vaddr     <= '0;
		end else begin
			if (cpu_read_en)
				cpu_rdata <= rd_mux;

			// A new frame end wins over a clearing read
			if (vga_done)
				vblank <= 1'b1;
			else if (rd_status)
				vblank <= 1'b0;

			if (rd_status)
				toggle <= 1'b0;

			if (cpu_write_en) begin
				case (cpu_addr)
					REG_CTRL:  render_en <= cpu_wdata[0];
					REG_COLOR: fg_color <= cpu_wdata;
					REG_SCROLL: begin
						if (toggle)
							scroll_y <= cpu_wdata;
						else
							scroll_x <= cpu_wdata;
						toggle <= !toggle;
					end
					REG_VADDR: begin
						if (toggle)
							vaddr[7:0] <= cpu_wdata; // Low byte second
						else
							vaddr[10:8] <= cpu_wdata[2:0];
						toggle <= !toggle;
					end
					REG_VDATA: vaddr <= vaddr + 1'b1;
					default: ;
				endcase
			end else if (rd_vdata) begin
				vaddr <= vaddr + 1'b1;
			end
		end
	end

	// Dual-port VRAM, CPU writes and renderer reads
	always_ff @(posedge clk) begin
		if (wr_vdata)
			vram[vaddr] <= cpu_wdata;
		ppu_vram_data <= vram[ppu_vram_addr];
	end

	bus_rw_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(cpu_write_en && cpu_read_en));

endmodule

`default_nettype wire

//--- hdl/ppu_render.sv
`timescale 1ns/1ps
`default_nettype none

module ppu_render (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  vga_done,
	input  wire ppu_pkg::byte_t      ppu_vram_data,
	output ppu_pkg::vram_addr_t      ppu_vram_addr,
	ppu_reg_if.render            regs,
	pix_wr_if.src                pix
);
	import ppu_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		FETCH_NAME,
		FETCH_PAT,
		WRITE
	} state_t;

	state_t     state;
	fb_coord_t  x;          // Frame position being drawn
	fb_coord_t  y;
	fb_coord_t  scroll_x;   // Latched at frame start
	fb_coord_t  scroll_y;
	fb_coord_t  src_x;
	fb_coord_t  src_y;
	logic [8:0] sum_y;
	vram_addr_t name_addr;
	vram_addr_t pat_addr;
	logic       pix_on;

	// Scrolled source position with the vertical wrap at 240
	assign src_x = x + scroll_x;
	assign sum_y = {1'b0, y} + {1'b0, scroll_y};
	assign src_y = (sum_y >= 9'(FB_H)) ? fb_coord_t'(sum_y - 9'(FB_H)) : sum_y[7:0];

	assign name_addr = vram_addr_t'({src_y[7:3], src_x[7:3]});
	// Name byte is on the data port during FETCH_PAT
	assign pat_addr  = PATTERN_BASE + vram_addr_t'({ppu_vram_data[6:0], src_y[2:0]});

	assign ppu_vram_addr = (state == FETCH_PAT) ? pat_addr : name_addr;

	// Pattern byte is on the data port during WRITE
	assign pix_on = ppu_vram_data[3'd7 - src_x[2:0]]; // Bit 7 leftmost

	assign pix.row      = y;
	assign pix.col      = x;
	assign pix.data     = pix_on ? regs.fg_color : '0;
	assign pix.write_en = (state == WRITE);

	assign regs.busy = (state != IDLE);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= IDLE;
			x        <= '0;
			y        <= '0;
			scroll_x <= '0;
			scroll_y <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (vga_done && regs.render_en) begin
						scroll_x <= regs.scroll_x;
						scroll_y <= regs.scroll_y;
						x        <= '0;
						y        <= '0;
						state    <= FETCH_NAME;
					end
				end
				FETCH_NAME: state <= FETCH_PAT;
				FETCH_PAT:  state <= WRITE;
				WRITE: begin
					x <= x + 1'b1; // Wraps to 0 at line end
					if (x == 8'(FB_W - 1)) begin
						if (y == 8'(FB_H - 1)) begin
							state <= IDLE; // Frame done
						end else begin
							y     <= y + 1'b1;
							state <= FETCH_NAME;
						end
					end else begin
						state <= FETCH_NAME;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	pix_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
		pix.write_en |-> (int'(pix.row) < FB_H && int'(pix.col) < FB_W));

endmodule

`default_nettype wire

//--- hdl/vga_mem.sv
`timescale 1ns/1ps
`default_nettype none

module vga_mem (
	input  wire                 clk,
	pix_wr_if.dst               pix,
	input  wire ppu_pkg::fb_coord_t vga_row,
	input  wire ppu_pkg::fb_coord_t vga_col,
	output ppu_pkg::pixel_t         vga_data
);
	import ppu_pkg::*;

	// Row-major, 256 bytes per row, so {row, col} is the address
	pixel_t fb [FB_SIZE];

	logic [15:0] wr_addr;
	logic [15:0] rd_addr;

	assign wr_addr = {pix.row, pix.col};
	assign rd_addr = {vga_row, vga_col};

	// Renderer side
	always_ff @(posedge clk) begin
		if (pix.write_en)
			fb[wr_addr] <= pix.data;
	end

	// Scan-out side, one cycle latency
	always_ff @(posedge clk) begin
		if (int'(rd_addr) < FB_SIZE)
			vga_data <= fb[rd_addr];
		else
			vga_data <= '0; // Rows past 239 during blanking
	end

endmodule

`default_nettype wire

//--- hdl/vga_controller.sv
`timescale 1ns/1ps
`default_nettype none

module vga_controller (
	input  wire                clk,
	input  wire                rst_n,
	input  wire ppu_pkg::pixel_t   vga_data,
	output ppu_pkg::fb_coord_t     vga_row,
	output ppu_pkg::fb_coord_t     vga_col,
	output logic               vga_done,
	output logic               vga_hsync,
	output logic               vga_vsync,
	output logic               vga_blank_n,
	output logic [7:0]         vga_r,
	output logic [7:0]         vga_g,
	output logic [7:0]         vga_b
);
	import ppu_pkg::*;

	scan_cnt_t h_cnt;
	scan_cnt_t v_cnt;
	logic      active;
	logic      border;   // Right of the 512-pixel picture
	logic      hsync_raw;
	logic      vsync_raw;
	logic      hsync_d;  // Stage 1, lines up with the RAM read
	logic      vsync_d;
	logic      blank_n_d;
	logic      border_d;
	pixel_t    px;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (h_cnt == scan_cnt_t'(H_TOTAL - 1)) begin
			h_cnt <= '0;
			if (v_cnt == scan_cnt_t'(V_TOTAL - 1))
				v_cnt <= '0;
			else
				v_cnt <= v_cnt + 1'b1;
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	assign active    = (h_cnt < scan_cnt_t'(H_ACTIVE)) && (v_cnt < scan_cnt_t'(V_ACTIVE));
	assign border    = (h_cnt >= scan_cnt_t'(2 * FB_W));
	assign hsync_raw = !((h_cnt >= scan_cnt_t'(H_ACTIVE + H_FP)) &&
		(h_cnt < scan_cnt_t'(H_ACTIVE + H_FP + H_SYNC)));
	assign vsync_raw = !((v_cnt >= scan_cnt_t'(V_ACTIVE + V_FP)) &&
		(v_cnt < scan_cnt_t'(V_ACTIVE + V_FP + V_SYNC)));

	// 2x scaling
	assign vga_row = v_cnt[8:1];
	assign vga_col = h_cnt[8:1];

	// First clock of line 480
	assign vga_done = (h_cnt == '0) && (v_cnt == scan_cnt_t'(V_ACTIVE));

	assign px = (blank_n_d && !border_d) ? vga_data : '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hsync_d     <= 1'b1;
			vsync_d     <= 1'b1;
			blank_n_d   <= 1'b0;
			border_d    <= 1'b0;
			vga_hsync   <= 1'b1;
			vga_vsync   <= 1'b1;
			vga_blank_n <= 1'b0;
			vga_r       <= '0;
			vga_g       <= '0;
			vga_b       <= '0;
		end else begin
			hsync_d     <= hsync_raw;
			vsync_d     <= vsync_raw;
			blank_n_d   <= active;
			border_d    <= border;
			vga_hsync   <= hsync_d;
			vga_vsync   <= vsync_d;
			vga_blank_n <= blank_n_d;
			// RGB332 to 8 bits per channel by bit replication
			vga_r <= {px[7:5], px[7:5], px[7:6]};
			vga_g <= {px[4:2], px[4:2], px[4:3]};
			vga_b <= {px[1:0], px[1:0], px[1:0], px[1:0]};
		end
	end

	done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		vga_done |=> !vga_done);

endmodule

`default_nettype wire

//--- hdl/ppu_mem_vga_top.sv
`timescale 1ns/1ps
`default_nettype none

module ppu_mem_vga_top (
	input  wire                 clk,
	input  wire                 rst_n,
	input  wire ppu_pkg::cpu_addr_t cpu_addr,
	input  wire ppu_pkg::byte_t     cpu_wdata,
	input  wire                 cpu_write_en,
	input  wire                 cpu_read_en,
	input  wire ppu_pkg::byte_t     joy_1,
	input  wire ppu_pkg::byte_t     joy_2,
	output ppu_pkg::byte_t          cpu_rdata,
	output logic                ppu_vsync,  // Vblank flag
	output logic                vga_hsync,
	output logic                vga_vsync,
	output logic                vga_blank_n,
	output logic [7:0]          vga_r,
	output logic [7:0]          vga_g,
	output logic [7:0]          vga_b
);
	import ppu_pkg::*;

	ppu_reg_if regs ();
	pix_wr_if  pix ();

	vram_addr_t ppu_vram_addr;
	byte_t      ppu_vram_data;
	logic       vga_done;
	fb_coord_t  vga_row;
	fb_coord_t  vga_col;
	pixel_t     vga_data;

	mem_ctrl mem_ctrl_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.cpu_addr      (cpu_addr),
		.cpu_wdata     (cpu_wdata),
		.cpu_write_en  (cpu_write_en),
		.cpu_read_en   (cpu_read_en),
		.joy_1         (joy_1),
		.joy_2         (joy_2),
		.vga_done      (vga_done),
		.ppu_vram_addr (ppu_vram_addr),
		.cpu_rdata     (cpu_rdata),
		.ppu_vram_data (ppu_vram_data),
		.vblank        (ppu_vsync),
		.regs          (regs.ctrl)
	);

	ppu_render ppu_render_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.vga_done      (vga_done),
		.ppu_vram_data (ppu_vram_data),
		.ppu_vram_addr (ppu_vram_addr),
		.regs          (regs.render),
		.pix           (pix.src)
	);

	vga_mem vga_mem_i (
		.clk      (clk),
		.pix      (pix.dst),
		.vga_row  (vga_row),
		.vga_col  (vga_col),
		.vga_data (vga_data)
	);

	vga_controller vga_ctrl_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.vga_data    (vga_data),
		.vga_row     (vga_row),
		.vga_col     (vga_col),
		.vga_done    (vga_done),
		.vga_hsync   (vga_hsync),
		.vga_vsync   (vga_vsync),
		.vga_blank_n (vga_blank_n),
		.vga_r       (vga_r),
		.vga_g       (vga_g),
		.vga_b       (vga_b)
	);

endmodule

`default_nettype wire

//--- tb/ppu_mem_vga_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ppu_mem_vga_tb;
	import ppu_pkg::*;

	localparam int N_CASES         = 4;
	localparam int FRAME_CYCLES    = H_TOTAL * V_TOTAL;
	localparam int WATCHDOG_CYCLES = (N_CASES + 4) * 3 * FRAME_CYCLES + 100_000;

	typedef struct packed {
		byte_t           scroll_x;
		byte_t           scroll_y; // Below 240
		pixel_t          fg;
		logic [3:0][7:0] fx;       // Sample frame columns
		logic [3:0][7:0] fy;       // Sample frame rows
	} render_case_t;

	logic       clk;
	logic       rst_n;
	cpu_addr_t  cpu_addr;
	byte_t      cpu_wdata;
	logic       cpu_write_en;
	logic       cpu_read_en;
	byte_t      joy_1;
	byte_t      joy_2;
	byte_t      cpu_rdata;
	logic       ppu_vsync;
	logic       vga_hsync;
	logic       vga_vsync;
	logic       vga_blank_n;
	logic [7:0] vga_r;
	logic [7:0] vga_g;
	logic [7:0] vga_b;

	byte_t           shadow [VRAM_SIZE]; // Mirror of the video RAM
	render_case_t    cases [N_CASES];
	int              scr_h [4];          // Screen coordinates to capture
	int              scr_v [4];
	logic [2:0][7:0] cap_rgb [4];
	logic [2:0][7:0] exp_rgb [4];

	ppu_mem_vga_top dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic fail_stop(input string what);
		$display("%s", what);
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_byte(input string name, input byte_t exp, input byte_t got);
		if (got !== exp)
			fail_stop($sformatf("[FAIL] %0t %s expected %02h got %02h", $time, name, exp, got));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic got);
		if (got !== exp)
			fail_stop($sformatf("[FAIL] %0t %s expected %b got %b", $time, name, exp, got));
	endtask

	task automatic check_rgb(input string name, input logic [7:0] exp_r, input logic [7:0] exp_g,
		input logic [7:0] exp_b, input logic [7:0] got_r, input logic [7:0] got_g,
		input logic [7:0] got_b);
		if (got_r !== exp_r || got_g !== exp_g || got_b !== exp_b)
			fail_stop($sformatf("[FAIL] %0t %s expected %02h_%02h_%02h got %02h_%02h_%02h",
				$time, name, exp_r, exp_g, exp_b, got_r, got_g, got_b));
	endtask

	task automatic bus_write(input cpu_addr_t addr, input byte_t data);
		@(posedge clk);
		cpu_addr     <= addr;
		cpu_wdata    <= data;
		cpu_write_en <= 1'b1;
		@(posedge clk);
		cpu_write_en <= 1'b0;
	endtask

	task automatic bus_read(input cpu_addr_t addr, output byte_t data);
		@(posedge clk);
		cpu_addr    <= addr;
		cpu_read_en <= 1'b1;
		@(posedge clk);
		cpu_read_en <= 1'b0;
		@(posedge clk);
		data = cpu_rdata; // Registered one edge after the strobe
	endtask

	task automatic set_vaddr(input vram_addr_t addr);
		bus_write(REG_VADDR, {5'b0, addr[10:8]});
		bus_write(REG_VADDR, addr[7:0]);
	endtask

	// Status poll, which also leaves the write toggle cleared
	task automatic wait_busy(input logic level);
		byte_t st;
		bus_read(REG_STATUS, st);
		while (st[6] !== level)
			bus_read(REG_STATUS, st);
	endtask

	function automatic pixel_t expected_pixel(input int fx, input int fy, input byte_t scx,
		input byte_t scy, input pixel_t fg);
		int    sx;
		int    sy;
		int    tile;
		byte_t pat;
		sx   = (fx + int'(scx)) % FB_W;
		sy   = (fy + int'(scy)) % FB_H;
		tile = int'(shadow[vram_addr_t'((sy / 8) * 32 + sx / 8)][6:0]);
		pat  = shadow[vram_addr_t'(int'(PATTERN_BASE) + tile * 8 + sy % 8)];
		return pat[3'(7 - sx % 8)] ? fg : 8'h00; // Bit 7 is the leftmost pixel
	endfunction

	function automatic logic [23:0] expand_rgb(input pixel_t c);
		return {c[7:5], c[7:5], c[7:6], c[4:2], c[4:2], c[4:3], {4{c[1:0]}}};
	endfunction

	// Lines are found from blank_n rises after vsync, columns from valid cycles
	task automatic capture_frame();
		int   line;
		int   col;
		logic prev_blank_n;
		bit   done;
		line         = -1;
		col          = 0;
		prev_blank_n = 1'b0;
		done         = 1'b0;
		@(posedge clk);
		while (vga_vsync)
			@(posedge clk);
		while (!vga_vsync)
			@(posedge clk);
		while (!done) begin
			@(posedge clk);
			if (vga_blank_n && !prev_blank_n) begin
				line++;
				col = 0;
			end
			if (vga_blank_n) begin
				for (int i = 0; i < 4; i++)
					if (line == scr_v[i] && col == scr_h[i])
						cap_rgb[i] = {vga_r, vga_g, vga_b};
				col++;
			end else if (prev_blank_n && line == V_ACTIVE - 1) begin
				done = 1'b1;
			end
			prev_blank_n = vga_blank_n;
		end
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		fail_stop($sformatf("Timeout: no result after %0d clock cycles", WATCHDOG_CYCLES));
	end

	initial begin
		byte_t d;
		int    frames;
		logic  prev_vs;
		rst_n        = 1'b0;
		cpu_addr     = '0;
		cpu_wdata    = '0;
		cpu_write_en = 1'b0;
		cpu_read_en  = 1'b0;
		joy_1        = '0;
		joy_2        = '0;
		void'($urandom(32'h0d4890ec));

		cases[0] = {8'd0, 8'd0, 8'hE0, {8'd0, 8'd7, 8'd128, 8'd255}, {8'd0, 8'd8, 8'd120, 8'd239}};
		cases[1] = {8'd3, 8'd17, 8'h1C, {8'd1, 8'd64, 8'd200, 8'd254}, {8'd2, 8'd100, 8'd223, 8'd238}};
		cases[2] = {8'd250, 8'd239, 8'h03, {8'd5, 8'd6, 8'd130, 8'd250}, {8'd0, 8'd1, 8'd119, 8'd239}};
		cases[3] = {8'd128, 8'd120, 8'hFF, {8'd9, 8'd127, 8'd128, 8'd33}, {8'd119, 8'd120, 8'd5, 8'd200}};

		// Reset values
		repeat (3) @(posedge clk);
		check_bit("vga_hsync", 1'b1, vga_hsync);
		check_bit("vga_vsync", 1'b1, vga_vsync);
		check_bit("vga_blank_n", 1'b0, vga_blank_n);
		check_byte("cpu_rdata", 8'h00, cpu_rdata);
		@(posedge clk);
		rst_n <= 1'b1;
		bus_read(REG_STATUS, d);
		check_byte("status", 8'h00, d);

		// Half an address pair, dropped by the status read
		bus_write(REG_VADDR, 8'h05);
		bus_read(REG_STATUS, d);
		set_vaddr(11'h7F8);
		for (int i = 0; i < VRAM_SIZE; i++) begin
			d = 8'($urandom);
			shadow[vram_addr_t'(i + 'h7F8)] = d; // Wraps past 0x7FF
			bus_write(REG_VDATA, d);
		end
		bus_read(REG_STATUS, d);
		set_vaddr(11'h000);
		for (int i = 0; i < VRAM_SIZE; i++) begin
			bus_read(REG_VDATA, d);
			check_byte("vram_data", shadow[vram_addr_t'(i)], d);
		end
		bus_read(REG_STATUS, d);
		set_vaddr(11'h7FC);
		for (int i = 0; i < 8; i++) begin
			bus_read(REG_VDATA, d);
			check_byte("vram_data", shadow[vram_addr_t'(i + 'h7FC)], d);
		end

		for (int i = 0; i < 8; i++) begin
			@(posedge clk);
			joy_1 <= 8'($urandom);
			joy_2 <= 8'($urandom);
			bus_read(REG_JOY1, d);
			check_byte("joy_1", joy_1, d);
			bus_read(REG_JOY2, d);
			check_byte("joy_2", joy_2, d);
		end
		bus_read(16'h3000, d);
		check_byte("unmapped", 8'h00, d);
		bus_read(16'h2003, d);
		check_byte("unmapped", 8'h00, d);

		// Vblank flag set by the frame end, cleared by one status read
		bus_read(REG_STATUS, d);
		while (!ppu_vsync)
			@(posedge clk);
		check_bit("vga_blank_n", 1'b0, vga_blank_n);
		bus_read(REG_STATUS, d);
		check_byte("status", 8'h80, d);
		bus_read(REG_STATUS, d);
		check_byte("status", 8'h00, d);
		check_bit("ppu_vsync", 1'b0, ppu_vsync);

		for (int r = 0; r < N_CASES; r++) begin
			bus_write(REG_CTRL, 8'h00);
			wait_busy(1'b0);
			bus_write(REG_SCROLL, cases[r].scroll_x);
			bus_write(REG_SCROLL, cases[r].scroll_y);
			bus_write(REG_COLOR, cases[r].fg);
			bus_write(REG_CTRL, 8'h01);
			wait_busy(1'b1);
			wait_busy(1'b0);
			for (int i = 0; i < 4; i++) begin
				scr_h[i]   = 2 * int'(cases[r].fx[i]) + (i & 1);
				scr_v[i]   = 2 * int'(cases[r].fy[i]) + (i >> 1);
				exp_rgb[i] = expand_rgb(expected_pixel(int'(cases[r].fx[i]),
					int'(cases[r].fy[i]), cases[r].scroll_x, cases[r].scroll_y, cases[r].fg));
			end
			capture_frame();
			for (int i = 0; i < 4; i++)
				check_rgb("vga_rgb", exp_rgb[i][2], exp_rgb[i][1], exp_rgb[i][0],
					cap_rgb[i][2], cap_rgb[i][1], cap_rgb[i][0]);
		end

		// Renderer off, so a new name table must not reach the screen
		bus_write(REG_CTRL, 8'h00);
		wait_busy(1'b0);
		set_vaddr(11'h000);
		for (int i = 0; i < 960; i++) begin
			d = ~shadow[vram_addr_t'(i)];
			shadow[vram_addr_t'(i)] = d;
			bus_write(REG_VDATA, d);
		end
		frames  = 0;
		prev_vs = vga_vsync;
		while (frames < 2) begin
			bus_read(REG_STATUS, d);
			check_bit("busy", 1'b0, d[6]);
			if (prev_vs && !vga_vsync)
				frames++;
			prev_vs = vga_vsync;
		end
		capture_frame(); // Same samples as the last case
		for (int i = 0; i < 4; i++)
			check_rgb("vga_rgb", exp_rgb[i][2], exp_rgb[i][1], exp_rgb[i][0],
				cap_rgb[i][2], cap_rgb[i][1], cap_rgb[i][0]);

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
hdl/ppu_pkg.sv
hdl/ppu_reg_if.sv
hdl/pix_wr_if.sv
hdl/mem_ctrl.sv
hdl/ppu_render.sv
hdl/vga_mem.sv
hdl/vga_controller.sv
hdl/ppu_mem_vga_top.sv
tb/ppu_mem_vga_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench into sim.log, check the result"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -f sources.f \
		--top-module ppu_mem_vga_tb -o ppu_sim
	./obj_dir/ppu_sim > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
